// ==== Bender.yml ====
package:
  name: rr_arbiter

sources:
  - verilog/arbPkg.sv
  - verilog/reqFilter.sv
  - verilog/rrArbiter.sv
  - verilog/arbRegs.sv
  - verilog/arbTop.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/arbTb.sv

// ==== list.f ====
+incdir+verification
verilog/arbPkg.sv
verilog/reqFilter.sv
verilog/rrArbiter.sv
verilog/arbRegs.sv
verilog/arbTop.sv
verification/arbTb.sv

// ==== verification/arbModel.svh ====
`ifndef ARB_MODEL_SVH
`define ARB_MODEL_SVH

// Reference copy of every register in the design
logic [FilterDepth-1:0] mHist [NumLines];
lineVecT mFilt;
lineVecT mMask;
lineVecT mGrant;
int      mPtr;

task automatic modelReset();
  foreach (mHist[i])
  begin
    mHist[i] = '0;
  end
  mFilt  = '0;
  mMask  = MaskReset;
  mGrant = '0;
  mPtr   = 0;
endtask

// One rising edge with the inputs that were applied during the cycle
task automatic modelStep(input lineVecT raw, input apbReqT req);
  lineVecT masked;
  lineVecT nextGrant;
  logic    found;
  int      line;
  masked    = mFilt & mMask;
  nextGrant = '0;
  found     = 1'b0;
  // First requester at or above the pointer, wrapping past line 7
  for (int k = 0; k < NumLines; k++)
  begin
    line = (mPtr + k) % NumLines;
    if (!found && masked[line])
    begin
      nextGrant[line] = 1'b1;
      found           = 1'b1;
    end
  end
  if (masked != '0 && (masked & mGrant) == '0)
  begin
    mPtr = (mPtr + 1) % NumLines;
  end
  mGrant = nextGrant;
  for (int i = 0; i < NumLines; i++)
  begin
    if (mHist[i] == '1)
      mFilt[i] = 1'b1;
    else if (mHist[i] == '0)
      mFilt[i] = 1'b0;
    mHist[i] = {mHist[i][FilterDepth-2:0], raw[i]};
  end
  if (req.sel && req.enable && req.write && req.addr == AddrMask)
  begin
    mMask = req.wdata[NumLines-1:0];
  end
endtask

function automatic logic expSlverr(input logic wr, input logic [7:0] addr);
  return (addr != AddrMask && addr != AddrStatus) || (addr == AddrStatus && wr);
endfunction

function automatic logic [31:0] expRead(input logic [7:0] addr);
  logic [31:0] word;
  word = '0;
  if (addr == AddrMask)
  begin
    word[7:0] = mMask;
  end
  else if (addr == AddrStatus)
  begin
    word[7:0] = mGrant;
    for (int i = 0; i < NumLines; i++)
    begin
      if (mGrant[i])
        word[10:8] = 3'(i);
    end
    word[11]    = |mGrant;
    word[23:16] = mFilt;
  end
  return word;
endfunction

`endif

// ==== verification/arbTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module arbTb
  import arbPkg::*;
();

  localparam int unsigned RandCycles     = 1400;
  localparam int unsigned DirectedCycles = 100;
  // Twice the expected length of all tests together
  localparam int unsigned CycleLimit     = 2 * (RandCycles + DirectedCycles);

  logic    AClkB;
  logic    AResetBN;
  lineVecT reqRaw;
  apbReqT  apbReq;
  apbRspT  apbRsp;
  lineVecT grant;
  int      errCount   = 0;
  int      testCount  = 0;
  int      failCount  = 0;
  int      cycleCount = 0;

  `include "arbModel.svh"

  arbTop u_dut
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .reqRaw   (reqRaw),
    .apbReq   (apbReq),
    .apbRsp   (apbRsp),
    .grant    (grant)
  );

  initial
  begin
    AClkB = 1'b0;
    forever
    begin
      #4 AClkB = ~AClkB;
    end
  end

  always @(posedge AClkB)
  begin
    cycleCount <= cycleCount + 1;
  end

  initial
  begin
    wait (cycleCount >= CycleLimit);
    $display("Timeout: run still going after %0d cycles", cycleCount);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errCount++;
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Model follows the same edge, grant is compared once it has settled
  task automatic stepCycle();
    @(posedge AClkB);
    if (AResetBN)
      modelStep(reqRaw, apbReq);
    #1;
    checkValue("grant", grant, mGrant);
  endtask

  task automatic apbTransfer(input logic wr, input logic [7:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata);
    apbReq = '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: data};
    stepCycle();
    apbReq.enable = 1'b1;
    #1;
    checkValue("apbRsp.ready", apbRsp.ready, 1);
    checkValue("apbRsp.slverr", apbRsp.slverr, expSlverr(wr, addr));
    if (!wr)
      checkValue("apbRsp.rdata", apbRsp.rdata, expRead(addr));
    rdata = apbRsp.rdata;
    stepCycle();
    apbReq = '0;
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testCount++;
    if (errCount == errBefore)
    begin
      $display("test %s: ok", name);
    end
    else
    begin
      failCount++;
      $display("test %s: failed with %0d errors", name, errCount - errBefore);
    end
  endtask

  initial
  begin
    logic [31:0] rd;
    int          errMark;
    int          delay;
    int          endCycle;
    int          op;
    int          holdLeft [NumLines];
    lineVecT     seen;
    void'($urandom(32'hf566));
    AResetBN = 1'b0;
    reqRaw   = '0;
    apbReq   = '0;
    modelReset();
    repeat (3) @(posedge AClkB);
    #1;
    AResetBN = 1'b1;

    errMark = errCount;
    stepCycle();
    checkValue("apbRsp.slverr", apbRsp.slverr, 0);
    apbTransfer(1'b0, AddrMask, '0, rd);
    apbTransfer(1'b0, AddrStatus, '0, rd);
    reportTest("reset", errMark);

    // Edges from the request change to the grant change
    errMark   = errCount;
    reqRaw[3] = 1'b1;
    delay     = 0;
    while (!grant[3] && delay < 20)
    begin
      stepCycle();
      delay++;
    end
    checkValue("grant rise latency", delay, FilterDepth + 2);
    reqRaw[3] = 1'b0;
    delay     = 0;
    while (grant[3] && delay < 20)
    begin
      stepCycle();
      delay++;
    end
    checkValue("grant fall latency", delay, FilterDepth + 2);
    reportTest("latency", errMark);

    errMark = errCount;
    seen    = '0;
    for (int w = 1; w < FilterDepth; w++)
    begin
      reqRaw[5] = 1'b1;
      for (int c = 0; c < w + FilterDepth + 2; c++)
      begin
        if (c == w)
          reqRaw[5] = 1'b0;
        stepCycle();
        seen = seen | grant;
      end
      apbTransfer(1'b0, AddrStatus, '0, rd);
      checkValue("status reqFilt", rd[23:16], 0);
    end
    assert (seen == '0)
    else
    begin
      errCount++;
      $display("A pulse shorter than the filter window produced a grant");
    end
    reportTest("glitch", errMark);

    errMark = errCount;
    apbTransfer(1'b1, AddrMask, 32'hffff_ff5a, rd);
    apbTransfer(1'b0, AddrMask, '0, rd);
    checkValue("mask readback", rd, 32'h0000_005a);
    apbTransfer(1'b1, AddrStatus, 32'h0000_00ff, rd);
    apbTransfer(1'b1, 8'h10, 32'h0000_00ff, rd);
    apbTransfer(1'b0, 8'h3c, '0, rd);
    checkValue("unmapped rdata", rd, 0);
    apbTransfer(1'b0, AddrMask, '0, rd);
    checkValue("mask after refused writes", rd, 32'h0000_005a);
    reportTest("registers", errMark);

    errMark  = errCount;
    endCycle = cycleCount + RandCycles;
    foreach (holdLeft[i])
      holdLeft[i] = 0;
    while (cycleCount < endCycle)
    begin
      for (int i = 0; i < NumLines; i++)
      begin
        if (holdLeft[i] > 0)
        begin
          holdLeft[i]--;
        end
        else
        begin
          reqRaw[i] = ~reqRaw[i];
          // Mostly long holds, now and then a short glitch
          if ($urandom % 4 == 0)
            holdLeft[i] = $urandom % 3;
          else
            holdLeft[i] = FilterDepth + $urandom % 30;
        end
      end
      op = $urandom % 24;
      if (op < 2)
        apbTransfer(1'b1, AddrMask, $urandom | $urandom, rd);
      else if (op == 2)
        apbTransfer(1'b0, AddrMask, '0, rd);
      else if (op == 3)
        apbTransfer(1'b0, AddrStatus, '0, rd);
      else if (op == 4)
        apbTransfer($urandom % 2, 8'h08 + 8'(4 * ($urandom % 60)), $urandom, rd);
      else if (op == 5)
        apbTransfer(1'b1, AddrStatus, $urandom, rd);
      else
        stepCycle();
    end
    reportTest("random", errMark);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             testCount, failCount, errCount);
    if (errCount == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/arbPkg.sv ====
`default_nettype none

package arbPkg;

  // Requester count and derived widths
  localparam int unsigned NumLines    = 8;
  localparam int unsigned IdxWidth    = 3;
  localparam int unsigned FilterDepth = 4;

  // APB geometry
  localparam int unsigned ApbAddrWidth = 8;
  localparam int unsigned ApbDataWidth = 32;

  // Register offsets
  localparam logic [ApbAddrWidth-1:0] AddrMask   = 8'h00;
  localparam logic [ApbAddrWidth-1:0] AddrStatus = 8'h04;

  // One bit per requester
  typedef logic [NumLines-1:0] lineVecT;

  // All lines enabled out of reset
  localparam lineVecT MaskReset = '1;

  typedef struct packed {
    logic                    sel;
    logic                    enable;
    logic                    write;
    logic [ApbAddrWidth-1:0] addr;
    logic [ApbDataWidth-1:0] wdata;
  } apbReqT;

  typedef struct packed {
    logic [ApbDataWidth-1:0] rdata;
    logic                    ready;
    logic                    slverr;
  } apbRspT;

  typedef struct packed {
    lineVecT             grant;
    logic [IdxWidth-1:0] grantIdx;
    logic                grantValid;
  } arbStatusT;

endpackage

`default_nettype wire

// ==== verilog/arbRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module arbRegs
  import arbPkg::*;
(
  input  logic      AClkB,
  input  logic      AResetBN,
  input  apbReqT    apbReq,
  output apbRspT    apbRsp,
  input  arbStatusT arbStatus,
  input  lineVecT   reqFilt,
  output lineVecT   enableMask
);

  // Status register layout, MSB first
  typedef struct packed {
    logic [7:0]          rsvdHi;
    lineVecT             reqFilt;
    logic [3:0]          rsvdMid;
    logic                grantValid;
    logic [IdxWidth-1:0] grantIdx;
    lineVecT             grant;
  } statusWordT;

  logic                    apbSetup;
  logic                    apbAccess;
  logic                    hitMask;
  logic                    hitStatus;
  logic                    accessErr;
  logic                    wrMask;
  statusWordT              statusWord;
  logic [ApbDataWidth-1:0] readData;

  assign apbSetup  = apbReq.sel & ~apbReq.enable;
  assign apbAccess = apbReq.sel & apbReq.enable;

  // Address decode
  assign hitMask   = (apbReq.addr == AddrMask);
  assign hitStatus = (apbReq.addr == AddrStatus);

  // Unmapped offsets and status writes are refused
  assign accessErr = ~(hitMask | hitStatus) | (hitStatus & apbReq.write);
  assign wrMask    = apbAccess & apbReq.write & hitMask;

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      enableMask <= MaskReset;
    end
    else if (wrMask)
    begin
      enableMask <= apbReq.wdata[NumLines-1:0];
    end
  end

  always_comb
  begin
    statusWord            = '0;
    statusWord.grant      = arbStatus.grant;
    statusWord.grantIdx   = arbStatus.grantIdx;
    statusWord.grantValid = arbStatus.grantValid;
    statusWord.reqFilt    = reqFilt;
  end

  // Read data only during a read access cycle
  always_comb
  begin
    readData = '0;
    if (apbAccess && !apbReq.write)
    begin
      if (hitMask)
      begin
        readData = ApbDataWidth'(enableMask);
      end
      else if (hitStatus)
      begin
        readData = statusWord;
      end
    end
  end

  // No wait states
  assign apbRsp = '{rdata: readData, ready: 1'b1, slverr: apbAccess & accessErr};

  assert property (@(posedge AClkB) disable iff (!AResetBN)
    $rose(apbReq.enable) |-> apbReq.sel)
  else
    $error("APB enable rose while sel was low");

  // Every access cycle follows its own setup cycle
  assert property (@(posedge AClkB) disable iff (!AResetBN)
    apbAccess |-> $past(apbSetup))
  else
    $error("APB access cycle without a preceding setup cycle");

endmodule

`default_nettype wire

// ==== verilog/arbTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module arbTop
  import arbPkg::*;
(
  input  logic    AClkB,
  input  logic    AResetBN,
  input  lineVecT reqRaw,
  input  apbReqT  apbReq,
  output apbRspT  apbRsp,
  output lineVecT grant
);

  lineVecT   reqFilt;
  lineVecT   reqMasked;
  lineVecT   enableMask;
  arbStatusT arbStatus;

  reqFilter uReqFilter
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .reqRaw   (reqRaw),
    .reqFilt  (reqFilt)
  );

  // Software enable gate
  assign reqMasked = reqFilt & enableMask;

  rrArbiter uRrArbiter
  (
    .AClkB     (AClkB),
    .AResetBN  (AResetBN),
    .reqMasked (reqMasked),
    .grant     (grant),
    .arbStatus (arbStatus)
  );

  arbRegs uArbRegs
  (
    .AClkB      (AClkB),
    .AResetBN   (AResetBN),
    .apbReq     (apbReq),
    .apbRsp     (apbRsp),
    .arbStatus  (arbStatus),
    .reqFilt    (reqFilt),
    .enableMask (enableMask)
  );

endmodule

`default_nettype wire

// ==== verilog/reqFilter.sv ====
`timescale 1ns/1ns
`default_nettype none

module reqFilter
  import arbPkg::*;
(
  input  logic    AClkB,
  input  logic    AResetBN,
  input  lineVecT reqRaw,
  output lineVecT reqFilt
);

  // Newest sample sits in bit 0 of each line
  logic [NumLines-1:0][FilterDepth-1:0] sampleHist;
  lineVecT histOnes;
  lineVecT histZeros;

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      sampleHist <= '0;
    end
    else
    begin
      for (int i = 0; i < NumLines; i++)
      begin
        sampleHist[i] <= {sampleHist[i][FilterDepth-2:0], reqRaw[i]};
      end
    end
  end

  // Uniform window detection per line
  always_comb
  begin
    for (int i = 0; i < NumLines; i++)
    begin
      histOnes[i]  = &sampleHist[i];
      histZeros[i] = ~|sampleHist[i];
    end
  end

  // Set on a full window of ones, clear on a full window of zeros, else hold
  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      reqFilt <= '0;
    end
    else
    begin
      reqFilt <= histOnes | (reqFilt & ~histZeros);
    end
  end

  // Any change of a filtered line must come from a settled window
  assert property (@(posedge AClkB) disable iff (!AResetBN)
    ((reqFilt ^ $past(reqFilt)) & ~$past(histOnes | histZeros)) == '0)
  else
    $error("reqFilt moved on a line whose sample window was mixed");

endmodule

`default_nettype wire

// ==== verilog/rrArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rrArbiter
  import arbPkg::*;
(
  input  logic      AClkB,
  input  logic      AResetBN,
  input  lineVecT   reqMasked,
  output lineVecT   grant,
  output arbStatusT arbStatus
);

  lineVecT             prioPtr;
  lineVecT             ptrNext;
  lineVecT             reqRot;
  lineVecT             lowerSeen;
  lineVecT             reqFirst;
  lineVecT             grantNext;
  logic                reqAny;
  logic                holdGrant;
  logic [IdxWidth-1:0] grantIdx;

  // Rotate requests down so the pointer line lands on bit 0
  always_comb
  begin
    reqRot = '0;
    for (int r = 0; r < NumLines; r++)
    begin
      for (int j = 0; j < NumLines; j++)
      begin
        reqRot[j] = reqRot[j] | (prioPtr[r] & reqMasked[(j + r) % NumLines]);
      end
    end
  end

  // Keep only the lowest set bit of the rotated vector
  always_comb
  begin
    lowerSeen[0] = reqRot[0];
    for (int j = 1; j < NumLines; j++)
    begin
      lowerSeen[j] = reqRot[j] | lowerSeen[j-1];
    end
  end

  assign reqFirst = reqRot & ~{lowerSeen[NumLines-2:0], 1'b0};

  // Rotate the winner back into line order
  always_comb
  begin
    grantNext = '0;
    for (int r = 0; r < NumLines; r++)
    begin
      for (int j = 0; j < NumLines; j++)
      begin
        grantNext[(j + r) % NumLines] = grantNext[(j + r) % NumLines] |
                                        (prioPtr[r] & reqFirst[j]);
      end
    end
  end

  // Pointer freezes while the current holder still requests
  assign reqAny    = |reqMasked;
  assign holdGrant = |(reqMasked & grant);
  assign ptrNext   = (reqAny && !holdGrant) ?
                     {prioPtr[NumLines-2:0], prioPtr[NumLines-1]} : prioPtr;

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      prioPtr <= lineVecT'(1);
      grant   <= '0;
    end
    else
    begin
      prioPtr <= ptrNext;
      grant   <= grantNext;
    end
  end

  // Index of the registered grant, one-hot input
  always_comb
  begin
    grantIdx = '0;
    for (int i = 0; i < NumLines; i++)
    begin
      if (grant[i])
      begin
        grantIdx = grantIdx | IdxWidth'(i);
      end
    end
  end

  assign arbStatus = '{grant: grant, grantIdx: grantIdx, grantValid: |grant};

  assert property (@(posedge AClkB) disable iff (!AResetBN) $onehot0(grant))
  else
    $error("grant is not one-hot: %b", grant);

  assert property (@(posedge AClkB) disable iff (!AResetBN) $onehot(prioPtr))
  else
    $error("priority pointer lost its one-hot form: %b", prioPtr);

  // A grant always answers last cycle's request
  assert property (@(posedge AClkB) disable iff (!AResetBN)
    (grant & ~$past(reqMasked)) == '0)
  else
    $error("grant %b given to a line that was not requesting", grant);

endmodule

`default_nettype wire
